//--- vlog.f
+incdir+common
common/mipsPkg.sv
src/ifu.sv
decode/ctrl.sv
decode/grf.sv
execute/execute.sv
result/resultStage.sv
src/mips.sv
bench/clkGen.sv
bench/tb_mips.sv

//--- run.sh
#!/usr/bin/env bash
# Build the MIPS testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    -f vlog.f --top-module tb_mips --Mdir obj_dir \
    && ./obj_dir/Vtb_mips | tee /dev/stderr | grep "^STATUS: PASS$" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: build or simulation failed"; exit 1; }

//--- bench/tb_mips.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module tb_mips;

    localparam int ClkPeriod      = 10;
    localparam int ResetCycles    = 16;
    localparam int WatchdogCycles = 2000;
    localparam int Retirements    = 1500;
    localparam int ProgWords      = 256;
    // Words of data memory that the prologue writes and the program touches
    localparam int MemRegion      = 16;
    localparam int BodyStart      = 3 * MemRegion + 1;
    localparam int MemBits        = $clog2(`DM_WORDS);

    logic            clk;
    logic            rst;
    logic [31:0]     pc;
    logic [31:0]     instr;
    mipsPkg::commitT commit;
    mipsPkg::commitT expected;

    int          errors;
    int          checks;
    logic [31:0] lcgState;
    logic [31:0] prog [0:ProgWords-1];
    logic [31:0] mRegs [0:31];
    logic [31:0] mMem [0:`DM_WORDS-1];
    logic [31:0] mPc;

    clkGen #(.HalfPeriod(ClkPeriod / 2), .ResetCycles(ResetCycles)) uClk (
        .clk (clk),
        .rst (rst)
    );

    mips u_mips (
        .clk    (clk),
        .rst    (rst),
        .pc     (pc),
        .instr  (instr),
        .commit (commit)
    );

    ////////////////////////////////////////
    // Program generation
    ////////////////////////////////////////

    function automatic logic [31:0] randWord();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic int randBelow(int n);
        return int'((randWord() >> 8) % n);
    endfunction

    function automatic logic [31:0] encodeR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                            logic [4:0] shamt, logic [5:0] fn);
        return {`OP_RTYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic logic [31:0] encodeI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                            logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJ(logic [5:0] op, logic [25:0] index);
        return {op, index};
    endfunction

    function automatic logic [31:0] addrOf(int idx);
        return `MIPS_RESET_PC + 32'(idx * 4);
    endfunction

    // Mostly forward and wrapping back to the body start
    function automatic int targetAfter(int idx);
        return BodyStart + ((idx + 1 + randBelow(12) - BodyStart) % (ProgWords - BodyStart));
    endfunction

    task automatic buildProgram();
        int          idx;
        int          t;
        logic [31:0] data;
        logic [31:0] tAddr;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        // Prologue fills the memory region so no load sees an unwritten word
        for (int k = 0; k < MemRegion; k++) begin
            data = randWord();
            prog[3*k]     = encodeI(`OP_LUI, 5'd0, 5'd1, data[31:16]);
            prog[3*k + 1] = encodeI(`OP_ORI, 5'd1, 5'd1, data[15:0]);
            prog[3*k + 2] = encodeI(`OP_SW, 5'd0, 5'd1, 16'(4 * k));
        end
        tAddr = addrOf(BodyStart);
        prog[BodyStart - 1] = encodeI(`OP_ORI, 5'd0, 5'd30, tAddr[15:0]);
        idx = BodyStart;
        while (idx < ProgWords - 1) begin
            rd = 5'(randBelow(30));
            rs = 5'(randBelow(32));
            rt = 5'(randBelow(32));
            case (randBelow(16))
                0:  prog[idx] = encodeR(rs, rt, rd, 5'd0, `FN_ADDU);
                1:  prog[idx] = encodeR(rs, rt, rd, 5'd0, `FN_SUBU);
                2:  prog[idx] = encodeR(rs, rt, rd, 5'd0, `FN_AND);
                3:  prog[idx] = encodeR(rs, rt, rd, 5'd0, `FN_OR);
                4:  prog[idx] = encodeR(rs, rt, rd, 5'd0, `FN_SLT);
                5:  prog[idx] = encodeR(5'd0, rt, rd, 5'(randBelow(32)), `FN_SLL);
                6:  prog[idx] = encodeI(`OP_ORI, rs, rd, 16'(randWord() >> 8));
                7:  prog[idx] = encodeI(`OP_ADDIU, rs, rd, 16'(randWord() >> 8));
                8:  prog[idx] = encodeI(`OP_LUI, 5'd0, rd, 16'(randWord() >> 8));
                9:  prog[idx] = encodeI(`OP_LW, 5'd0, rd, 16'(4 * randBelow(MemRegion)));
                10: prog[idx] = encodeI(`OP_LB, 5'd0, rd, 16'(randBelow(4 * MemRegion)));
                11: prog[idx] = encodeI(`OP_SW, 5'd0, rt, 16'(4 * randBelow(MemRegion)));
                12: prog[idx] = encodeI(`OP_SB, 5'd0, rt, 16'(randBelow(4 * MemRegion)));
                13: begin
                    // Few source registers so both outcomes show up
                    t = targetAfter(idx);
                    prog[idx] = encodeI(randBelow(2) == 0 ? `OP_BEQ : `OP_BNE,
                                        5'(randBelow(8)), 5'(randBelow(8)), 16'(t - idx - 1));
                end
                14: begin
                    tAddr = addrOf(targetAfter(idx));
                    prog[idx] = encodeJ(randBelow(2) == 0 ? `OP_J : `OP_JAL, tAddr[27:2]);
                end
                default: begin
                    if (idx < ProgWords - 2) begin
                        tAddr = addrOf(targetAfter(idx + 1));
                        prog[idx] = encodeI(`OP_ORI, 5'd0, 5'd30, tAddr[15:0]);
                        idx++;
                        prog[idx] = encodeR(5'd30, 5'd0, 5'd0, 5'd0, `FN_JR);
                    end else begin
                        prog[idx] = 32'd0;
                    end
                end
            endcase
            idx++;
        end
        tAddr = addrOf(BodyStart);
        prog[ProgWords - 1] = encodeJ(`OP_J, tAddr[27:2]);
    endtask

    // Outside the program the core sees sll $0,$0,0
    function automatic logic [31:0] fetchWord(logic [31:0] addr);
        logic [31:0] offs;
        offs = addr - `MIPS_RESET_PC;
        if (offs < 32'(ProgWords * 4)) begin
            return prog[offs[9:2]];
        end
        return 32'd0;
    endfunction

    ////////////////////////////////////////
    // Instruction-set model
    ////////////////////////////////////////

    task automatic modelStep(output mipsPkg::commitT exp);
        logic [31:0] iw;
        logic [31:0] rsV;
        logic [31:0] rtV;
        logic [31:0] simm;
        logic [31:0] pc4;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] res;
        logic [31:0] npc;
        logic [7:0]  b;
        logic [4:0]  dst;
        logic        we;
        iw   = fetchWord(mPc);
        rsV  = mRegs[iw[25:21]];
        rtV  = mRegs[iw[20:16]];
        simm = {{16{iw[15]}}, iw[15:0]};
        addr = rsV + simm;
        pc4  = mPc + 32'd4;
        npc  = pc4;
        dst  = iw[20:16];
        we   = 1'b0;
        res  = 32'd0;
        exp  = '0;
        exp.valid = 1'b1;
        exp.pc    = mPc;
        case (iw[31:26])
            `OP_RTYPE: begin
                dst = iw[15:11];
                we  = 1'b1;
                case (iw[5:0])
                    `FN_ADDU: res = rsV + rtV;
                    `FN_SUBU: res = rsV - rtV;
                    `FN_AND:  res = rsV & rtV;
                    `FN_OR:   res = rsV | rtV;
                    `FN_SLT:  res = ($signed(rsV) < $signed(rtV)) ? 32'd1 : 32'd0;
                    `FN_SLL:  res = rtV << iw[10:6];
                    `FN_JR: begin
                        we  = 1'b0;
                        npc = rsV;
                    end
                    default:  we = 1'b0;
                endcase
            end
            `OP_ORI: begin
                we  = 1'b1;
                res = rsV | {16'd0, iw[15:0]};
            end
            `OP_ADDIU: begin
                we  = 1'b1;
                res = rsV + simm;
            end
            `OP_LUI: begin
                we  = 1'b1;
                res = {iw[15:0], 16'd0};
            end
            `OP_LW: begin
                we  = 1'b1;
                res = mMem[addr[MemBits+1:2]];
            end
            `OP_LB: begin
                word = mMem[addr[MemBits+1:2]];
                b    = word[{addr[1:0], 3'b000} +: 8];
                we   = 1'b1;
                res  = {{24{b[7]}}, b};
            end
            `OP_SW, `OP_SB: begin
                word = rtV;
                if (iw[31:26] == `OP_SB) begin
                    word = mMem[addr[MemBits+1:2]];
                    word[{addr[1:0], 3'b000} +: 8] = rtV[7:0];
                end
                mMem[addr[MemBits+1:2]] = word;
                exp.memWe   = 1'b1;
                exp.memAddr = addr;
                exp.memData = word;
            end
            `OP_BEQ: if (rsV == rtV) npc = pc4 + (simm << 2);
            `OP_BNE: if (rsV != rtV) npc = pc4 + (simm << 2);
            `OP_J:   npc = {pc4[31:28], iw[25:0], 2'b00};
            `OP_JAL: begin
                npc = {pc4[31:28], iw[25:0], 2'b00};
                dst = 5'd31;
                we  = 1'b1;
                res = pc4;
            end
            default: we = 1'b0;
        endcase
        // Register 0 writes never show as retired
        if (we && dst != 5'd0) begin
            mRegs[dst]  = res;
            exp.regWe   = 1'b1;
            exp.regAddr = dst;
            exp.regData = res;
        end
        mPc = npc;
    endtask

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    task automatic checkValue(string name, logic [31:0] want, logic [31:0] got);
        checks++;
        assert (want === got) else begin
            errors++;
            $display("[FAIL] %s expected %h actual %h", name, want, got);
        end
    endtask

    task automatic checkCommit(mipsPkg::commitT exp);
        checkValue("commit.valid", {31'd0, exp.valid}, {31'd0, commit.valid});
        checkValue("commit.pc", exp.pc, commit.pc);
        checkValue("commit.regWe", {31'd0, exp.regWe}, {31'd0, commit.regWe});
        if (exp.regWe) begin
            checkValue("commit.regAddr", {27'd0, exp.regAddr}, {27'd0, commit.regAddr});
            checkValue("commit.regData", exp.regData, commit.regData);
        end
        checkValue("commit.memWe", {31'd0, exp.memWe}, {31'd0, commit.memWe});
        if (exp.memWe) begin
            checkValue("commit.memAddr", exp.memAddr, commit.memAddr);
            checkValue("commit.memData", exp.memData, commit.memData);
        end
        assert (!(commit.valid && commit.regWe && commit.regAddr == 5'd0)) else begin
            errors++;
            $display("commit at pc %h reported a write to register 0", commit.pc);
        end
    endtask

    // Fetch port serving one program word per pc
    initial begin
        instr = 32'd0;
        forever begin
            @(posedge clk);
            #1 instr = fetchWord(pc);
        end
    end

    initial begin
        errors   = 0;
        checks   = 0;
        lcgState = 32'hc04e;
        mPc      = `MIPS_RESET_PC;
        for (int i = 0; i < 32; i++) begin
            mRegs[i] = 32'd0;
        end
        buildProgram();

        // Every reset cycle holds the reset pc and no retirement
        @(posedge clk);
        @(negedge clk);
        while (rst) begin
            checkValue("reset pc", `MIPS_RESET_PC, pc);
            checkValue("reset commit.valid", 32'd0, {31'd0, commit.valid});
            @(negedge clk);
        end
        checkValue("first cycle pc", `MIPS_RESET_PC, pc);
        checkValue("first cycle commit.valid", 32'd0, {31'd0, commit.valid});

        for (int n = 0; n < Retirements; n++) begin
            modelStep(expected);
            @(negedge clk);
            checkCommit(expected);
            checkValue("next pc", mPc, pc);
        end

        $display("retirements %0d checks %0d errors %0d", Retirements, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #((ResetCycles + WatchdogCycles) * ClkPeriod);
        $display("watchdog expired before %0d retirements were checked", Retirements);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- bench/clkGen.sv
`timescale 1ns/1ps

module clkGen #(
    parameter int HalfPeriod  = 5,
    parameter int ResetCycles = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // Release just after an edge, like the other stimulus
    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

//--- src/mips.sv
`timescale 1ns/1ps

module mips (
    input  logic            clk,
    input  logic            rst,
    output logic [31:0]     pc,
    input  logic [31:0]     instr,
    output mipsPkg::commitT commit
);

    mipsPkg::ctrlT ctrl;
    logic [31:0]   rsVal;
    logic [31:0]   rtVal;
    logic [31:0]   aluResult;
    logic          taken;
    logic [4:0]    wbAddr;
    logic [31:0]   wbData;
    logic          wbEn;

    ////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////

    ifu uIfu (
        .clk   (clk),
        .rst   (rst),
        .ctrl  (ctrl),
        .taken (taken),
        .instr (instr),
        .rsVal (rsVal),
        .pc    (pc)
    );

    ////////////////////////////////////////
    // Decode and register read
    ////////////////////////////////////////

    ctrl uCtrl (
        .instr (instr),
        .ctrl  (ctrl)
    );

    grf uGrf (
        .clk    (clk),
        .rst    (rst),
        .rsAddr (instr[25:21]),
        .rtAddr (instr[20:16]),
        .wbEn   (wbEn),
        .wbAddr (wbAddr),
        .wbData (wbData),
        .rsVal  (rsVal),
        .rtVal  (rtVal)
    );

    ////////////////////////////////////////
    // Execute, memory and write-back
    ////////////////////////////////////////

    execute uExecute (
        .instr     (instr),
        .ctrl      (ctrl),
        .rsVal     (rsVal),
        .rtVal     (rtVal),
        .aluResult (aluResult),
        .taken     (taken)
    );

    resultStage uResult (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .ctrl      (ctrl),
        .pc        (pc),
        .aluResult (aluResult),
        .rtVal     (rtVal),
        .wbEn      (wbEn),
        .wbAddr    (wbAddr),
        .wbData    (wbData),
        .commit    (commit)
    );

endmodule

//--- result/resultStage.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module resultStage (
    input  logic            clk,
    input  logic            rst,
    input  logic [31:0]     instr,
    input  mipsPkg::ctrlT   ctrl,
    input  logic [31:0]     pc,
    input  logic [31:0]     aluResult,
    input  logic [31:0]     rtVal,
    output logic            wbEn,
    output logic [4:0]      wbAddr,
    output logic [31:0]     wbData,
    output mipsPkg::commitT commit
);

    localparam int AddrBits = $clog2(`DM_WORDS);

    logic [31:0]         dataMem [0:`DM_WORDS-1];
    logic [AddrBits-1:0] wordIdx;
    logic [1:0]          byteLane;
    logic [31:0]         memWord;
    logic [7:0]          loadByte;
    logic [31:0]         loadData;
    logic [31:0]         storeWord;
    mipsPkg::commitT     commitNext;

    ////////////////////////////////////////
    // Data memory
    ////////////////////////////////////////

    assign wordIdx  = aluResult[AddrBits+1:2];
    assign byteLane = aluResult[1:0];
    assign memWord  = dataMem[wordIdx];
    assign loadByte = memWord[8*byteLane +: 8];
    assign loadData = (ctrl.dmOp == mipsPkg::dmByte) ? {{24{loadByte[7]}}, loadByte} : memWord;

    // sb merges one lane into the current word
    always_comb begin
        storeWord = rtVal;
        if (ctrl.dmOp == mipsPkg::dmByte) begin
            storeWord                   = memWord;
            storeWord[8*byteLane +: 8]  = rtVal[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst && ctrl.memWrite) begin
            dataMem[wordIdx] <= storeWord;
        end
    end

    ////////////////////////////////////////
    // Write-back
    ////////////////////////////////////////

    always_comb begin
        case (ctrl.regDst)
            mipsPkg::dstRd: wbAddr = instr[15:11];
            mipsPkg::dstRa: wbAddr = 5'd31;
            default:        wbAddr = instr[20:16];
        endcase
        case (ctrl.wbSel)
            mipsPkg::wbMem: wbData = loadData;
            mipsPkg::wbPc4: wbData = pc + 32'd4;
            default:        wbData = aluResult;
        endcase
    end

    // Writes to $0 are dropped here so they never show as retired
    assign wbEn = ctrl.regWrite && (wbAddr != 5'd0);

    // Retirement record, registered one cycle behind
    always_comb begin
        commitNext.valid   = 1'b1;
        commitNext.pc      = pc;
        commitNext.regWe   = wbEn;
        commitNext.regAddr = wbAddr;
        commitNext.regData = wbData;
        commitNext.memWe   = ctrl.memWrite;
        commitNext.memAddr = aluResult;
        commitNext.memData = storeWord;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            commit <= '0;
        end else begin
            commit <= commitNext;
        end
    end

    wordAligned: assert property (@(posedge clk) disable iff (rst)
        (ctrl.memRead || ctrl.memWrite) && ctrl.dmOp == mipsPkg::dmWord
        |-> aluResult[1:0] == 2'b00)
        else $error("resultStage: misaligned word access at %h", aluResult);

endmodule

//--- execute/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic [31:0]   instr,
    input  mipsPkg::ctrlT ctrl,
    input  logic [31:0]   rsVal,
    input  logic [31:0]   rtVal,
    output logic [31:0]   aluResult,
    output logic          taken
);

    logic [31:0] immExt;
    logic [31:0] srcB;

    ////////////////////////////////////////
    // Operand preparation
    ////////////////////////////////////////

    // Sign for addiu and memory offsets, zero for ori
    assign immExt = ctrl.extSigned ? {{16{instr[15]}}, instr[15:0]}
                                   : {16'd0, instr[15:0]};

    always_comb begin
        case (ctrl.srcBSel)
            mipsPkg::srcBImm:   srcB = immExt;
            mipsPkg::srcBShamt: srcB = {27'd0, instr[10:6]};
            default:            srcB = rtVal;
        endcase
    end

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (ctrl.aluOp)
            mipsPkg::aluAdd: aluResult = rsVal + srcB;
            mipsPkg::aluSub: aluResult = rsVal - srcB;
            mipsPkg::aluAnd: aluResult = rsVal & srcB;
            mipsPkg::aluOr:  aluResult = rsVal | srcB;
            mipsPkg::aluSlt: aluResult = {31'd0, $signed(rsVal) < $signed(srcB)};
            // sll shifts rt, not rs
            mipsPkg::aluSll: aluResult = rtVal << srcB[4:0];
            mipsPkg::aluLui: aluResult = {srcB[15:0], 16'd0};
            default:         aluResult = 32'd0;
        endcase
    end

    // Branch decision
    always_comb begin
        case (ctrl.cmpOp)
            mipsPkg::cmpEq: taken = (rsVal == rtVal);
            mipsPkg::cmpNe: taken = (rsVal != rtVal);
            default:        taken = 1'b0;
        endcase
    end

endmodule

//--- decode/grf.sv
`timescale 1ns/1ps

module grf (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  logic        wbEn,
    input  logic [4:0]  wbAddr,
    input  logic [31:0] wbData,
    output logic [31:0] rsVal,
    output logic [31:0] rtVal
);

    // $0 is not stored, reads of it are forced to zero
    logic [31:0] regs [1:31];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wbEn && wbAddr != 5'd0) begin
            regs[wbAddr] <= wbData;
        end
    end

    ////////////////////////////////////////
    // Read ports, old value on same-cycle write
    ////////////////////////////////////////

    assign rsVal = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
    assign rtVal = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];

    // Destination comes from the result stage decode of instr
    wbAddrKnown: assert property (@(posedge clk) disable iff (rst)
        wbEn |-> !$isunknown(wbAddr))
        else $error("grf: write enable with unknown address");

endmodule

//--- decode/ctrl.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module ctrl (
    input  logic [31:0]   instr,
    output mipsPkg::ctrlT ctrl
);

    // No writes, fall through to pc+4
    localparam mipsPkg::ctrlT NopCtrl = '{
        regWrite:  1'b0,
        regDst:    mipsPkg::dstRt,
        extSigned: 1'b0,
        srcBSel:   mipsPkg::srcBReg,
        aluOp:     mipsPkg::aluAdd,
        memWrite:  1'b0,
        memRead:   1'b0,
        dmOp:      mipsPkg::dmWord,
        wbSel:     mipsPkg::wbAlu,
        npcOp:     mipsPkg::npcSeq,
        cmpOp:     mipsPkg::cmpNone
    };

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl = NopCtrl;
        case (opcode)
            `OP_RTYPE: begin
                ctrl.regDst = mipsPkg::dstRd;
                case (funct)
                    `FN_ADDU: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluAdd;
                    end
                    `FN_SUBU: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluSub;
                    end
                    `FN_AND: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluAnd;
                    end
                    `FN_OR: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluOr;
                    end
                    `FN_SLT: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = mipsPkg::aluSlt;
                    end
                    `FN_SLL: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.srcBSel  = mipsPkg::srcBShamt;
                        ctrl.aluOp    = mipsPkg::aluSll;
                    end
                    `FN_JR:  ctrl.npcOp = mipsPkg::npcReg;
                    default: ctrl = NopCtrl;
                endcase
            end

            ////////////////////////////////////////
            // Immediate arithmetic and logic
            ////////////////////////////////////////
            `OP_ORI: begin
                ctrl.regWrite = 1'b1;
                ctrl.srcBSel  = mipsPkg::srcBImm;
                ctrl.aluOp    = mipsPkg::aluOr;
            end
            `OP_ADDIU: begin
                ctrl.regWrite  = 1'b1;
                ctrl.extSigned = 1'b1;
                ctrl.srcBSel   = mipsPkg::srcBImm;
            end
            `OP_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.srcBSel  = mipsPkg::srcBImm;
                ctrl.aluOp    = mipsPkg::aluLui;
            end

            ////////////////////////////////////////
            // Loads and stores, address is rs+simm
            ////////////////////////////////////////
            `OP_LW, `OP_LB: begin
                ctrl.regWrite  = 1'b1;
                ctrl.extSigned = 1'b1;
                ctrl.srcBSel   = mipsPkg::srcBImm;
                ctrl.memRead   = 1'b1;
                ctrl.wbSel     = mipsPkg::wbMem;
                ctrl.dmOp      = (opcode == `OP_LB) ? mipsPkg::dmByte : mipsPkg::dmWord;
            end
            `OP_SW, `OP_SB: begin
                ctrl.extSigned = 1'b1;
                ctrl.srcBSel   = mipsPkg::srcBImm;
                ctrl.memWrite  = 1'b1;
                ctrl.dmOp      = (opcode == `OP_SB) ? mipsPkg::dmByte : mipsPkg::dmWord;
            end

            // Control transfer
            `OP_BEQ: begin
                ctrl.npcOp = mipsPkg::npcBranch;
                ctrl.cmpOp = mipsPkg::cmpEq;
            end
            `OP_BNE: begin
                ctrl.npcOp = mipsPkg::npcBranch;
                ctrl.cmpOp = mipsPkg::cmpNe;
            end
            `OP_J:   ctrl.npcOp = mipsPkg::npcJump;
            `OP_JAL: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = mipsPkg::dstRa;
                ctrl.wbSel    = mipsPkg::wbPc4;
                ctrl.npcOp    = mipsPkg::npcJump;
            end
            default: ctrl = NopCtrl;
        endcase
    end

endmodule

//--- src/ifu.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module ifu (
    input  logic          clk,
    input  logic          rst,
    input  mipsPkg::ctrlT ctrl,
    input  logic          taken,
    input  logic [31:0]   instr,
    input  logic [31:0]   rsVal,
    output logic [31:0]   pc
);

    logic [31:0] pcPlus4;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic [31:0] nextPc;

    assign pcPlus4 = pc + 32'd4;

    // Offset counts words relative to the following instruction
    assign branchTarget = pcPlus4 + {{14{instr[15]}}, instr[15:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};

    always_comb begin
        case (ctrl.npcOp)
            mipsPkg::npcBranch: nextPc = taken ? branchTarget : pcPlus4;
            mipsPkg::npcJump:   nextPc = jumpTarget;
            mipsPkg::npcReg:    nextPc = rsVal;
            default:            nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `MIPS_RESET_PC;
        end else begin
            pc <= nextPc;
        end
    end

    // A jr through a misaligned register would break fetch
    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("ifu: pc %h not word aligned", pc);

endmodule

//--- common/mipsPkg.sv
package mipsPkg;

    ////////////////////////////////////////
    // Datapath selectors
    ////////////////////////////////////////

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluLui
    } aluOpT;

    // Branch condition, cmpNone for everything but beq/bne
    typedef enum logic [1:0] {cmpNone, cmpEq, cmpNe} cmpOpT;

    typedef enum logic [1:0] {npcSeq, npcBranch, npcJump, npcReg} npcOpT;

    typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;

    typedef enum logic [1:0] {srcBReg, srcBImm, srcBShamt} srcBSelT;

    typedef enum logic [1:0] {wbAlu, wbMem, wbPc4} wbSelT;

    typedef enum logic {dmWord, dmByte} dmOpT;

    ////////////////////////////////////////
    // Decoder output bundle
    ////////////////////////////////////////

    typedef struct packed {
        logic    regWrite;
        regDstT  regDst;
        logic    extSigned;
        srcBSelT srcBSel;
        aluOpT   aluOp;
        logic    memWrite;
        logic    memRead;
        dmOpT    dmOp;
        wbSelT   wbSel;
        npcOpT   npcOp;
        cmpOpT   cmpOp;
    } ctrlT;

    // One retired instruction, as seen from outside
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        regWe;
        logic [4:0]  regAddr;
        logic [31:0] regData;
        logic        memWe;
        logic [31:0] memAddr;
        logic [31:0] memData;
    } commitT;

endpackage

//--- common/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

////////////////////////////////////////
// Core configuration
////////////////////////////////////////

// First fetch address out of reset
`define MIPS_RESET_PC 32'h00003000

// Data memory depth in 32-bit words
`define DM_WORDS 1024

////////////////////////////////////////
// Opcode field, instr[31:26]
////////////////////////////////////////

`define OP_RTYPE 6'b000000
`define OP_ORI   6'b001101
`define OP_ADDIU 6'b001001
`define OP_LUI   6'b001111
`define OP_LW    6'b100011
`define OP_LB    6'b100000
`define OP_SW    6'b101011
`define OP_SB    6'b101000
`define OP_BEQ   6'b000100
`define OP_BNE   6'b000101
`define OP_J     6'b000010
`define OP_JAL   6'b000011

// Funct field for R-type, instr[5:0]
`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_SLT  6'b101010
`define FN_SLL  6'b000000
`define FN_JR   6'b001000

`endif
